/* include/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Main opcodes, instruction bits 31:26
`define OP_RTYPE 6'h00 // Register format, operation chosen by funct
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b
`define OP_BEQ   6'h04
`define OP_J     6'h02

// Funct codes for R-type, instruction bits 5:0
`define FUNCT_ADD 6'h20
`define FUNCT_SUB 6'h22
`define FUNCT_AND 6'h24
`define FUNCT_OR  6'h25
`define FUNCT_SLT 6'h2a

// Datapath word
`define WORD_WIDTH 32

// Memories are word addressed
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

// Wide enough for either memory
`define MEM_ADDR_WIDTH 6

`endif

/* hdl/mips_pkg.sv */
`include "mips_macros.svh"

package mips_pkg;

	// Datapath word
	typedef logic [`WORD_WIDTH-1:0] wordT;

	// Register format view of an instruction word
	// Immediate is bits 15:0, jump target bits 25:0
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt; // Not executed
		logic [5:0] funct;
	} instrT;

	// ALU class from the main decoder
	typedef enum logic [1:0] {
		ALU_ADD   = 2'b00, // Address calc and addi
		ALU_SUB   = 2'b01, // Compare for beq
		ALU_FUNCT = 2'b10  // R-type, look at funct
	} aluOpT;

	// Operation actually executed by the ALU
	typedef enum logic [2:0] {
		FUNC_ADD,
		FUNC_SUB,
		FUNC_AND,
		FUNC_OR,
		FUNC_SLT
	} aluFuncT;

	typedef struct packed {
		logic  regWrite; // Write back to rt or rd
		logic  memToReg; // Write-back from load data
		logic  memRead;
		logic  memWrite;
		logic  isBranch; // Taken when ALU zero
		logic  regDst;   // 1 selects rd
		aluOpT aluOp;
		logic  aluSrc;   // 1 selects immediate
		logic  isJump;
	} ctrlT;

	// One store as seen outside the core
	typedef struct packed {
		logic [29:0] addr; // Word address
		wordT        data;
	} storeT;

endpackage

/* hdl/control.sv */
`include "mips_macros.svh"

module control (
	input  logic             clk,    // Only for the checker
	input  logic             reset,
	input  logic [5:0]       opcode,
	output mips_pkg::ctrlT   ctrl
);

	always_comb begin
		ctrl = '0; // Unknown opcode falls through as a no-op
		case (opcode)
			`OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = 1'b1; // Destination in rd
				ctrl.aluOp    = mips_pkg::ALU_FUNCT;
			end
			`OP_ADDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = mips_pkg::ALU_ADD;
				ctrl.aluSrc   = 1'b1;
			end
			`OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.aluOp    = mips_pkg::ALU_ADD; // Base plus offset
				ctrl.aluSrc   = 1'b1;
			end
			`OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluOp    = mips_pkg::ALU_ADD;
				ctrl.aluSrc   = 1'b1;
			end
			`OP_BEQ: begin
				// Subtract so that zero means rs equals rt
				ctrl.isBranch = 1'b1;
				ctrl.aluOp    = mips_pkg::ALU_SUB;
			end
			`OP_J: begin
				ctrl.isJump = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

	// Next-PC mux in the core has no priority between these two
	assert property (@(posedge clk) disable iff (reset)
		!(ctrl.isJump && ctrl.isBranch))
	else $error("control: jump and branch decoded together, opcode %h", opcode);

endmodule

/* hdl/alu.sv */
`include "mips_macros.svh"

module alu (
	input  mips_pkg::aluOpT aluOp,
	input  logic [5:0]      funct,
	input  mips_pkg::wordT  a,
	input  mips_pkg::wordT  b,
	output mips_pkg::wordT  result,
	output logic            zero
);

	mips_pkg::aluFuncT func;

	// Operation select from class and funct
	always_comb begin
		case (aluOp)
			mips_pkg::ALU_ADD: func = mips_pkg::FUNC_ADD;
			mips_pkg::ALU_SUB: func = mips_pkg::FUNC_SUB;
			mips_pkg::ALU_FUNCT: begin
				case (funct)
					`FUNCT_ADD: func = mips_pkg::FUNC_ADD;
					`FUNCT_SUB: func = mips_pkg::FUNC_SUB;
					`FUNCT_AND: func = mips_pkg::FUNC_AND;
					`FUNCT_OR:  func = mips_pkg::FUNC_OR;
					`FUNCT_SLT: func = mips_pkg::FUNC_SLT;
					default:    func = mips_pkg::FUNC_ADD; // Unsupported funct adds
				endcase
			end
			default: func = mips_pkg::FUNC_ADD; // Code 11 unused
		endcase
	end

	// Datapath
	always_comb begin
		case (func)
			mips_pkg::FUNC_ADD: result = a + b;
			mips_pkg::FUNC_SUB: result = a - b;
			mips_pkg::FUNC_AND: result = a & b;
			mips_pkg::FUNC_OR:  result = a | b;
			mips_pkg::FUNC_SLT: begin
				// Signed compare, result is 1 or 0
				result = mips_pkg::wordT'($signed(a) < $signed(b));
			end
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0); // Used by beq

endmodule

/* hdl/registerFile.sv */
module registerFile (
	input  logic           clk,
	input  logic           reset,
	input  logic           writeEnable,
	input  logic [4:0]     writeAddr,
	input  mips_pkg::wordT writeData,
	input  logic [4:0]     readAddrA,
	input  logic [4:0]     readAddrB,
	output mips_pkg::wordT readDataA,
	output mips_pkg::wordT readDataB
);

	mips_pkg::wordT regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && (writeAddr != 5'd0)) begin
			regs[writeAddr] <= writeData; // r0 never written
		end
	end

	// Combinational reads, r0 forced for clarity
	assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

	// Core must hold off write-back while the program loads
	assert property (@(posedge clk) reset |-> !writeEnable)
	else $error("registerFile: write to r%0d during reset", writeAddr);

endmodule

/* hdl/memoryArray.sv */
`include "mips_macros.svh"

module memoryArray #(
	parameter type payloadT = mips_pkg::wordT,
	parameter int  depth    = `DMEM_DEPTH
) (
	input  logic                       clk,
	input  logic                       writeEnable,
	input  logic [`MEM_ADDR_WIDTH-1:0] writeAddr,
	input  payloadT                    writeData,
	input  logic [`MEM_ADDR_WIDTH-1:0] readAddr,
	output payloadT                    readData
);

	payloadT mem [depth]; // Contents undefined until written

	always_ff @(posedge clk) begin
		if (writeEnable) begin
			mem[writeAddr] <= writeData;
		end
	end

	assign readData = mem[readAddr]; // Asynchronous read

	// Catches an address width larger than the array
	assert property (@(posedge clk) writeEnable |-> (writeAddr < depth))
	else $error("memoryArray: write address %0d beyond depth %0d", writeAddr, depth);

endmodule

/* hdl/mipsCore.sv */
`include "mips_macros.svh"

module mipsCore (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       progWrite, // Honoured only in reset
	input  logic [`MEM_ADDR_WIDTH-1:0] progAddr,
	input  mips_pkg::instrT            progData,
	output logic                       storeValid,
	output mips_pkg::storeT            store,
	output mips_pkg::wordT             pc
);

	mips_pkg::instrT instr;
	mips_pkg::ctrlT  ctrl;
	mips_pkg::wordT  imm;          // Sign-extended immediate
	mips_pkg::wordT  pcPlus4;
	mips_pkg::wordT  branchTarget;
	mips_pkg::wordT  jumpTarget;
	mips_pkg::wordT  nextPc;
	mips_pkg::wordT  rsData;
	mips_pkg::wordT  rtData;
	mips_pkg::wordT  aluB;
	mips_pkg::wordT  aluResult;
	mips_pkg::wordT  dmemData;
	mips_pkg::wordT  loadData;
	mips_pkg::wordT  writeBack;
	logic [4:0]      writeReg;
	logic            aluZero;
	logic            regWriteEn;
	logic            memWriteEn;

	// PC register, 0 while held in reset
	always_ff @(posedge clk) begin
		if (reset) pc <= '0;
		else       pc <= nextPc;
	end

	assign pcPlus4      = pc + 32'd4;
	assign imm          = {{(`WORD_WIDTH-16){instr[15]}}, instr[15:0]};
	assign branchTarget = pcPlus4 + {imm[`WORD_WIDTH-3:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00}; // Same 256 MB region

	always_comb begin
		nextPc = pcPlus4;
		if (ctrl.isJump) nextPc = jumpTarget;
		else if (ctrl.isBranch && aluZero) nextPc = branchTarget;
	end

	memoryArray #(.payloadT(mips_pkg::instrT), .depth(`IMEM_DEPTH)) i_imem (
		.clk         (clk),
		.writeEnable (progWrite && reset), // Loader port
		.writeAddr   (progAddr),
		.writeData   (progData),
		.readAddr    (pc[`MEM_ADDR_WIDTH+1:2]),
		.readData    (instr)
	);

	control i_control (.clk(clk), .reset(reset), .opcode(instr.opcode), .ctrl(ctrl));

	assign regWriteEn = ctrl.regWrite && !reset;
	assign writeReg   = ctrl.regDst ? instr.rd : instr.rt;

	registerFile i_registerFile (
		.clk         (clk),
		.reset       (reset),
		.writeEnable (regWriteEn),
		.writeAddr   (writeReg),
		.writeData   (writeBack),
		.readAddrA   (instr.rs),
		.readAddrB   (instr.rt),
		.readDataA   (rsData),
		.readDataB   (rtData)
	);

	assign aluB = ctrl.aluSrc ? imm : rtData;

	alu i_alu (
		.aluOp  (ctrl.aluOp),
		.funct  (instr.funct),
		.a      (rsData),
		.b      (aluB),
		.result (aluResult),
		.zero   (aluZero)
	);

	assign memWriteEn = ctrl.memWrite && !reset;

	memoryArray #(.payloadT(mips_pkg::wordT), .depth(`DMEM_DEPTH)) i_dmem (
		.clk         (clk),
		.writeEnable (memWriteEn),
		.writeAddr   (aluResult[`MEM_ADDR_WIDTH+1:2]), // Byte to word address
		.writeData   (rtData),
		.readAddr    (aluResult[`MEM_ADDR_WIDTH+1:2]),
		.readData    (dmemData)
	);

	assign loadData  = ctrl.memRead ? dmemData : '0;
	assign writeBack = ctrl.memToReg ? loadData : aluResult;

	// Store strobe mirrors the data memory write
	assign storeValid = memWriteEn;
	assign store      = '{addr: aluResult[`WORD_WIDTH-1:2], data: rtData};

endmodule

/* bench/mipsCoreTb.sv */
`include "mips_macros.svh"

module mipsCoreTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PROG_LEN     = 30;
	localparam int NUM_STORES   = 11;
	localparam int RESET_CYCLES = 10;
	localparam int TIMEOUT      = 200; // Cycles allowed per expected store
	localparam int HOLD_CYCLES  = (PROG_LEN + 1 > RESET_CYCLES) ? PROG_LEN + 1 : RESET_CYCLES;

	logic                       clk;
	logic                       reset;
	logic                       progWrite;
	logic [`MEM_ADDR_WIDTH-1:0] progAddr;
	mips_pkg::instrT            progData;
	logic                       storeValid;
	mips_pkg::storeT            store;
	mips_pkg::wordT             pc;

	mips_pkg::instrT prog [PROG_LEN];       // Program image, word per entry
	mips_pkg::storeT expStore [NUM_STORES]; // Stores in program order
	int errorCount   = 0;
	int timeoutCount = 0;

	mipsCore i_mipsCore (
		.clk        (clk),
		.reset      (reset),
		.progWrite  (progWrite),
		.progAddr   (progAddr),
		.progData   (progData),
		.storeValid (storeValid),
		.store      (store),
		.pc         (pc)
	);

	always #2 clk = ~clk; // 4 ns period

	function automatic mips_pkg::instrT rType(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
		rType = {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mips_pkg::instrT iType(input logic [5:0] op, input logic [4:0] rs, rt,
			input logic [15:0] imm);
		iType = {op, rs, rt, imm};
	endfunction

	function automatic mips_pkg::instrT jType(input logic [25:0] target);
		jType = {`OP_J, target}; // Target is a word index
	endfunction

	task automatic buildTables();
		prog[0]  = iType(`OP_ADDI, 5'd0, 5'd1, 16'd5);       // r1 = 5
		prog[1]  = iType(`OP_ADDI, 5'd0, 5'd2, 16'd3);       // r2 = 3
		prog[2]  = iType(`OP_ADDI, 5'd0, 5'd3, -16'sd7);     // r3 = -7
		prog[3]  = rType(5'd1, 5'd2, 5'd4, `FUNCT_ADD);
		prog[4]  = iType(`OP_SW, 5'd0, 5'd4, 16'd0);
		prog[5]  = rType(5'd1, 5'd2, 5'd5, `FUNCT_SUB);
		prog[6]  = iType(`OP_SW, 5'd0, 5'd5, 16'd4);
		prog[7]  = rType(5'd1, 5'd2, 5'd6, `FUNCT_AND);
		prog[8]  = iType(`OP_SW, 5'd0, 5'd6, 16'd8);
		prog[9]  = rType(5'd1, 5'd2, 5'd7, `FUNCT_OR);
		prog[10] = iType(`OP_SW, 5'd0, 5'd7, 16'd12);
		prog[11] = rType(5'd3, 5'd1, 5'd8, `FUNCT_SLT);       // -7 < 5
		prog[12] = iType(`OP_SW, 5'd0, 5'd8, 16'd16);
		prog[13] = rType(5'd1, 5'd3, 5'd9, `FUNCT_SLT);       // 5 < -7
		prog[14] = iType(`OP_SW, 5'd0, 5'd9, 16'd20);
		prog[15] = iType(`OP_ADDI, 5'd0, 5'd10, 16'd40);     // Base pointer
		prog[16] = iType(`OP_SW, 5'd10, 5'd1, -16'sd8);      // Byte 32
		prog[17] = iType(`OP_LW, 5'd10, 5'd11, -16'sd8);     // Read it back into r11
		prog[18] = iType(`OP_SW, 5'd10, 5'd11, 16'd4);       // Byte 44
		prog[19] = iType(`OP_BEQ, 5'd1, 5'd1, 16'd1);        // Taken
		prog[20] = iType(`OP_SW, 5'd0, 5'd1, 16'd48);        // Skipped
		prog[21] = iType(`OP_BEQ, 5'd1, 5'd2, 16'd1);        // Falls through
		prog[22] = iType(`OP_SW, 5'd0, 5'd2, 16'd52);
		prog[23] = jType(26'd25);
		prog[24] = iType(`OP_SW, 5'd0, 5'd3, 16'd56);        // Jumped over
		prog[25] = iType(6'h3f, 5'd0, 5'd1, 16'h0063);       // Unknown opcode aimed at r1
		prog[26] = iType(`OP_SW, 5'd0, 5'd1, 16'd60);
		prog[27] = iType(`OP_ADDI, 5'd0, 5'd0, 16'd9);       // Write to r0
		prog[28] = iType(`OP_SW, 5'd0, 5'd0, 16'd64);
		prog[29] = jType(26'd29);                            // Park here

		expStore[0]  = '{addr: 30'd0,  data: 32'd8};  // 5 + 3
		expStore[1]  = '{addr: 30'd1,  data: 32'd2};  // 5 - 3
		expStore[2]  = '{addr: 30'd2,  data: 32'd1};  // 5 & 3
		expStore[3]  = '{addr: 30'd3,  data: 32'd7};  // 5 | 3
		expStore[4]  = '{addr: 30'd4,  data: 32'd1};
		expStore[5]  = '{addr: 30'd5,  data: 32'd0};
		expStore[6]  = '{addr: 30'd8,  data: 32'd5};  // 40 - 8 bytes
		expStore[7]  = '{addr: 30'd11, data: 32'd5};  // Same data as the load source
		expStore[8]  = '{addr: 30'd13, data: 32'd3};
		expStore[9]  = '{addr: 30'd15, data: 32'd5};  // r1 untouched by the no-op
		expStore[10] = '{addr: 30'd16, data: 32'd0};
	endtask

	task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual,
			input string msg);
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR %0t ns: %s, expected %h, got %h", $time, msg, expected, actual);
		end
	endtask

	// Steps a cycle at a time until a store shows up
	task automatic waitForStore(input int idx, output bit found);
		int n;
		found = 1'b0;
		for (n = 0; n < TIMEOUT && !storeValid; n++) begin
			@(posedge clk);
			#1;
		end
		if (storeValid) found = 1'b1;
		else $display("Store %0d never arrived within %0d cycles", idx, TIMEOUT);
	endtask

	initial begin
		bit found;
		bit stopped;
		clk       = 1'b0;
		reset     = 1'b1;
		progWrite = 1'b0;
		progAddr  = '0;
		progData  = '0;
		stopped   = 1'b0;
		buildTables();

		// Reset also covers the whole program load
		for (int c = 0; c < HOLD_CYCLES; c++) begin
			@(posedge clk);
			#1;
			checkValue(32'd0, pc, "pc during reset");
			checkValue(32'd0, storeValid, "storeValid during reset");
			if (c < PROG_LEN) begin
				progWrite = 1'b1;
				progAddr  = c;
				progData  = prog[c];
			end else begin
				progWrite = 1'b0;
			end
		end
		reset = 1'b0;

		// First instruction retires at the first edge after reset
		@(posedge clk);
		#1;
		checkValue(32'd4, pc, "pc after first instruction");

		for (int s = 0; s < NUM_STORES && !stopped; s++) begin
			waitForStore(s, found);
			if (found) begin
				checkValue(expStore[s].addr, store.addr, $sformatf("store %0d address", s));
				checkValue(expStore[s].data, store.data, $sformatf("store %0d data", s));
				@(posedge clk);
				#1;
			end else begin
				timeoutCount++;
				stopped = 1'b1;
			end
		end

		// Core should now sit on its self-jump
		for (int c = 0; c < 40 && !stopped; c++) begin
			if (storeValid) begin
				errorCount++;
				$display("Unexpected extra store to word %0d at %0t ns", store.addr, $time);
			end
			@(posedge clk);
			#1;
		end

		$display("Checks done: %0d errors, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+include
hdl/mips_pkg.sv
hdl/control.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/memoryArray.sv
hdl/mipsCore.sv
bench/mipsCoreTb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - target: rtl
    include_dirs:
      - include
    files:
      - hdl/mips_pkg.sv
      - hdl/control.sv
      - hdl/alu.sv
      - hdl/registerFile.sv
      - hdl/memoryArray.sv
      - hdl/mipsCore.sv
  - target: bench
    include_dirs:
      - include
    files:
      - bench/mipsCoreTb.sv
